// ==== block_ram.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module block_ram (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::bus_req_t bus,
	output cpu_pkg::bus_rsp_t rsp
);

	localparam int AW = $clog2(`CPU_RAM_WORDS);

	logic [31:0]   mem [`CPU_RAM_WORDS];
	logic [AW-1:0] idx;
	logic          ready_q;
	logic [31:0]   rdata_q;

	// word address, byte offset dropped.
	assign idx = bus.addr[AW+1:2];

	always_ff @(posedge clk)
	begin
		if (reset)
			ready_q <= 1'b0;
		else
			ready_q <= bus.rd | bus.wr;
	end

	always_ff @(posedge clk)
	begin
		if (bus.wr)
			mem[idx] <= bus.wdata;
		if (bus.rd)
			rdata_q <= mem[idx];
	end

	assign rsp.ready = ready_q;
	assign rsp.rdata = rdata_q;

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::bus_req_t ext_bus,
	input  cpu_pkg::bus_req_t cache_bus,
	output cpu_pkg::bus_req_t ram_bus,
	input  cpu_pkg::bus_rsp_t ram_rsp,
	output logic              ext_ack,
	output logic              cache_ack,
	output cpu_pkg::bus_rsp_t ext_rsp,
	output cpu_pkg::bus_rsp_t cache_rsp
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_EXT,
		OWN_CACHE
	} owner_t;

	owner_t owner;

	// loader wins when both ask in the same cycle.
	always_ff @(posedge clk)
	begin
		if (reset)
			owner <= OWN_NONE;
		else if (ram_rsp.ready)
			owner <= OWN_NONE;
		else if (owner == OWN_NONE)
		begin
			if (ext_bus.req)
				owner <= OWN_EXT;
			else if (cache_bus.req)
				owner <= OWN_CACHE;
		end
	end

	assign ext_ack   = (owner == OWN_EXT);
	assign cache_ack = (owner == OWN_CACHE);

	always_comb
	begin
		ram_bus = '0;
		if (ext_ack)
			ram_bus = ext_bus;
		else if (cache_ack)
			ram_bus = cache_bus;
	end

	// response goes back to the owner only.
	assign ext_rsp   = ext_ack ? ram_rsp : '0;
	assign cache_rsp = cache_ack ? ram_rsp : '0;

endmodule

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// instruction cache lines, one word each.
// must stay a power of two.
`define CPU_ICACHE_LINES 16

// block RAM depth in words.
`define CPU_RAM_WORDS 256

// first fetch address, in bytes.
`define CPU_RESET_PC 0

`endif

// ==== cpu_pkg.sv ====
package cpu_pkg;

	// opcode field, top nibble of every instruction.
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_MOVI = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_ORR  = 4'd5,
		OP_EOR  = 4'd6,
		OP_B    = 4'd7
	} opcode_t;

	typedef struct packed {
		opcode_t     op;
		logic [3:0]  rd;
		logic [3:0]  rn;
		logic [3:0]  rm;
		logic [15:0] imm;
	} insn_t;

	// master side of the word bus.
	typedef struct packed {
		logic        req;
		logic        rd;
		logic        wr;
		logic [31:0] addr;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic        bubble;
		insn_t       insn;
		logic [31:0] pc;
	} fetch_out_t;

	typedef struct packed {
		logic        bubble;
		opcode_t     op;
		logic [3:0]  rd;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] target;
	} issue_out_t;

	// one register write, also the forwarding path.
	typedef struct packed {
		logic        valid;
		logic [3:0]  num;
		logic [31:0] data;
	} commit_t;

endpackage

// ==== cpu_stim.txt ====
# P byte_addr word: program image written before run
# W reg value: expected commits in order; R byte_addr word: loader read-back
P 00000000 11001234
P 00000004 120000f0
P 00000008 23120000
P 0000000c 70000006
P 00000010 1900dead
P 00000014 1a00beef
P 00000018 34310000
P 0000001c 45410000
P 00000020 56530000
P 00000024 00000000
P 00000028 67610000
P 0000002c 70000006
P 00000030 1b000bad
P 00000034 1c00face
W 1 00001234
W 2 000000f0
W 3 00001324
W 4 000000f0
W 5 00000030
W 6 00001334
W 7 00000100
W 4 000000f0
W 5 00000030
W 6 00001334
W 7 00000100
R 00000008 23120000
R 0000002c 70000006
R 00000034 1c00face

// ==== cpu_system.sv ====
`timescale 1ns/1ps

module cpu_system (
	input  logic              clk,
	input  logic              reset,
	input  logic              run,
	input  cpu_pkg::bus_req_t ext_bus,
	output logic              ext_ack,
	output cpu_pkg::bus_rsp_t ext_rsp,
	output cpu_pkg::commit_t  commit
);

	cpu_pkg::bus_req_t   cache_bus;
	cpu_pkg::bus_req_t   ram_bus;
	cpu_pkg::bus_rsp_t   ram_rsp;
	cpu_pkg::bus_rsp_t   cache_rsp;
	logic                cache_ack;
	logic [31:0]         icache_rd_addr;
	logic                icache_rd_req;
	logic                icache_rd_wait;
	logic [31:0]         icache_rd_data;
	cpu_pkg::fetch_out_t fetch_out;
	cpu_pkg::issue_out_t issue_out;
	logic [3:0]          regfile_read_0;
	logic [3:0]          regfile_read_1;
	logic [31:0]         regfile_rdata_0;
	logic [31:0]         regfile_rdata_1;
	logic                jmp;
	logic [31:0]         jmppc;

	bus_arbiter u_bus_arbiter (
		.clk(clk), .reset(reset),
		.ext_bus(ext_bus), .cache_bus(cache_bus),
		.ram_bus(ram_bus), .ram_rsp(ram_rsp),
		.ext_ack(ext_ack), .cache_ack(cache_ack),
		.ext_rsp(ext_rsp), .cache_rsp(cache_rsp));

	block_ram u_block_ram (
		.clk(clk), .reset(reset),
		.bus(ram_bus), .rsp(ram_rsp));

	icache u_icache (
		.clk(clk), .reset(reset),
		.rd_addr(icache_rd_addr), .rd_req(icache_rd_req),
		.rd_wait(icache_rd_wait), .rd_data(icache_rd_data),
		.bus(cache_bus), .bus_ack(cache_ack), .bus_rsp(cache_rsp));

	fetch u_fetch (
		.clk(clk), .reset(reset), .run(run),
		.rd_addr(icache_rd_addr), .rd_req(icache_rd_req),
		.rd_wait(icache_rd_wait), .rd_data(icache_rd_data),
		.jmp(jmp), .jmppc(jmppc), .out(fetch_out));

	// the branch in execute also flushes issue.
	issue u_issue (
		.clk(clk), .reset(reset), .flush(jmp), .in(fetch_out),
		.read_0(regfile_read_0), .read_1(regfile_read_1),
		.rdata_0(regfile_rdata_0), .rdata_1(regfile_rdata_1),
		.fwd(commit), .out(issue_out));

	regfile u_regfile (
		.clk(clk), .reset(reset),
		.read_0(regfile_read_0), .read_1(regfile_read_1),
		.rdata_0(regfile_rdata_0), .rdata_1(regfile_rdata_1),
		.write(commit));

	execute u_execute (
		.clk(clk), .reset(reset), .in(issue_out),
		.commit(commit), .jmp(jmp), .jmppc(jmppc));

endmodule

// ==== execute.sv ====
`timescale 1ns/1ps

module execute (
	input  logic                clk,
	input  logic                reset,
	input  cpu_pkg::issue_out_t in,
	output cpu_pkg::commit_t    commit,
	output logic                jmp,
	output logic [31:0]         jmppc
);

	cpu_pkg::issue_out_t q;
	logic [31:0]         result;
	logic                writes;

	always_ff @(posedge clk)
	begin
		q <= in;
		if (reset)
			q.bubble <= 1'b1;
	end

	always_comb
	begin
		result = '0;
		writes = 1'b1;
		case (q.op)
			cpu_pkg::OP_MOVI: result = q.op_a;
			cpu_pkg::OP_ADD:  result = q.op_a + q.op_b;
			cpu_pkg::OP_SUB:  result = q.op_a - q.op_b;
			cpu_pkg::OP_AND:  result = q.op_a & q.op_b;
			cpu_pkg::OP_ORR:  result = q.op_a | q.op_b;
			cpu_pkg::OP_EOR:  result = q.op_a ^ q.op_b;
			default:          writes = 1'b0;
		endcase
	end

	assign commit.valid = writes && !q.bubble;
	assign commit.num   = q.rd;
	assign commit.data  = result;

	// squashes the two younger words through fetch and issue.
	assign jmp   = !q.bubble && (q.op == cpu_pkg::OP_B);
	assign jmppc = q.target;

endmodule

// ==== fetch.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module fetch (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	output logic [31:0]         rd_addr,
	output logic                rd_req,
	input  logic                rd_wait,
	input  logic [31:0]         rd_data,
	input  logic                jmp,
	input  logic [31:0]         jmppc,
	output cpu_pkg::fetch_out_t out
);

	logic [31:0] pc;
	logic        deliver;

	// a word leaves fetch only on a hit with no redirect pending.
	assign deliver = run && !rd_wait && !jmp;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `CPU_RESET_PC;
		else if (jmp)
			pc <= jmppc;
		else if (deliver)
			pc <= pc + 32'd4;
	end

	assign rd_addr = pc;
	assign rd_req  = run;

	assign out.bubble = !deliver;
	assign out.insn   = cpu_pkg::insn_t'(rd_data);
	assign out.pc     = pc;

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module icache (
	input  logic              clk,
	input  logic              reset,
	input  logic [31:0]       rd_addr,
	input  logic              rd_req,
	output logic              rd_wait,
	output logic [31:0]       rd_data,
	output cpu_pkg::bus_req_t bus,
	input  logic              bus_ack,
	input  cpu_pkg::bus_rsp_t bus_rsp
);

	localparam int IDX_W = $clog2(`CPU_ICACHE_LINES);
	localparam int TAG_W = 30 - IDX_W;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT_ACK,
		ST_STROBE,
		ST_WAIT_READY
	} state_t;

	state_t                       state;
	logic [TAG_W-1:0]             tags [`CPU_ICACHE_LINES];
	logic [31:0]                  lines [`CPU_ICACHE_LINES];
	logic [`CPU_ICACHE_LINES-1:0] valid;
	logic [IDX_W-1:0]             idx;
	logic [TAG_W-1:0]             tag;
	logic                         hit;
	logic [31:0]                  fill_addr;
	logic [IDX_W-1:0]             fill_idx;

	assign idx      = rd_addr[IDX_W+1:2];
	assign tag      = rd_addr[31:IDX_W+2];
	assign hit      = valid[idx] && (tags[idx] == tag);
	assign rd_wait  = rd_req && !hit;
	assign rd_data  = lines[idx];
	assign fill_idx = fill_addr[IDX_W+1:2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			valid <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (rd_wait)
						state <= ST_REQ;
				ST_REQ:
					state <= ST_WAIT_ACK;
				ST_WAIT_ACK:
					if (bus_ack)
						state <= ST_STROBE;
				ST_STROBE:
					state <= ST_WAIT_READY;
				ST_WAIT_READY:
					if (bus_rsp.ready)
					begin
						valid[fill_idx] <= 1'b1;
						state           <= ST_IDLE;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// miss address is held, a redirect during the fill does not move it.
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && rd_wait)
			fill_addr <= {rd_addr[31:2], 2'b00};
		if (state == ST_WAIT_READY && bus_rsp.ready)
		begin
			lines[fill_idx] <= bus_rsp.rdata;
			tags[fill_idx]  <= fill_addr[31:IDX_W+2];
		end
	end

	assign bus.req   = (state != ST_IDLE);
	assign bus.rd    = (state == ST_STROBE);
	assign bus.wr    = 1'b0;
	assign bus.addr  = fill_addr;
	assign bus.wdata = '0;

endmodule

// ==== issue.sv ====
`timescale 1ns/1ps

module issue (
	input  logic                clk,
	input  logic                reset,
	input  logic                flush,
	input  cpu_pkg::fetch_out_t in,
	output logic [3:0]          read_0,
	output logic [3:0]          read_1,
	input  logic [31:0]         rdata_0,
	input  logic [31:0]         rdata_1,
	input  cpu_pkg::commit_t    fwd,
	output cpu_pkg::issue_out_t out
);

	cpu_pkg::fetch_out_t q;
	cpu_pkg::insn_t      insn;
	logic [31:0]         reg_a;
	logic [31:0]         reg_b;

	always_ff @(posedge clk)
	begin
		q <= in;
		if (reset)
			q.bubble <= 1'b1;
	end

	assign insn   = q.insn;
	assign read_0 = insn.rn;
	assign read_1 = insn.rm;

	// the write in execute has not reached the regfile yet.
	always_comb
	begin
		reg_a = rdata_0;
		reg_b = rdata_1;
		if (fwd.valid && fwd.num == insn.rn)
			reg_a = fwd.data;
		if (fwd.valid && fwd.num == insn.rm)
			reg_b = fwd.data;
	end

	always_comb
	begin
		out.bubble = q.bubble || flush;
		out.op     = insn.op;
		out.rd     = insn.rd;
		out.op_b   = reg_b;
		out.target = {14'd0, insn.imm, 2'b00};
		if (insn.op == cpu_pkg::OP_MOVI)
			out.op_a = {16'd0, insn.imm};
		else
			out.op_a = reg_a;
	end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic             clk,
	input  logic             reset,
	input  logic [3:0]       read_0,
	input  logic [3:0]       read_1,
	output logic [31:0]      rdata_0,
	output logic [31:0]      rdata_1,
	input  cpu_pkg::commit_t write
);

	logic [31:0] regs [16];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end
		else if (write.valid)
			regs[write.num] <= write.data;
	end

	assign rdata_0 = regs[read_0];
	assign rdata_1 = regs[read_1];

endmodule

// ==== sim.f ====
+incdir+.
cpu_pkg.sv
bus_arbiter.sv
block_ram.sv
icache.sv
fetch.sv
issue.sv
regfile.sv
execute.sv
cpu_system.sv
tb_cpu_system.sv

// ==== tb_cpu_system.sv ====
`timescale 1ns/1ps

module tb_cpu_system;

	logic              clk;
	logic              reset;
	logic              run;
	cpu_pkg::bus_req_t ext_bus;
	logic              ext_ack;
	cpu_pkg::bus_rsp_t ext_rsp;
	cpu_pkg::commit_t  commit;

	logic [31:0] prog_addr [$];
	logic [31:0] prog_data [$];
	logic [3:0]  exp_num [$];
	logic [31:0] exp_data [$];
	logic [31:0] rb_addr [$];
	logic [31:0] rb_data [$];
	int          cycle_limit;
	int          cycle_count;
	int          commits_seen;
	int          seed_draw;

	cpu_system u_dut (
		.clk(clk), .reset(reset), .run(run),
		.ext_bus(ext_bus), .ext_ack(ext_ack), .ext_rsp(ext_rsp),
		.commit(commit));

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			abort_run($sformatf("FAIL at %0t ns: %s expected %08h actual %08h",
				$time, name, expected, actual));
	endtask

	// lines are P addr data, W reg data or R addr data; # starts a comment.
	task automatic load_stimulus();
		int               fd;
		int               n;
		byte              kind;
		logic [31:0]      a;
		logic [31:0]      d;
		logic [8*128-1:0] rest;
		fd = $fopen("cpu_stim.txt", "r");
		if (fd == 0)
			abort_run("could not open the stimulus file cpu_stim.txt");
		while ($fscanf(fd, " %c", kind) == 1)
		begin
			if (kind == "#")
				n = $fgets(rest, fd);
			else
			begin
				n = $fscanf(fd, " %h %h", a, d);
				if (n != 2)
					abort_run("a record in cpu_stim.txt is missing its fields");
				case (kind)
					"P":
					begin
						prog_addr.push_back(a);
						prog_data.push_back(d);
					end
					"W":
					begin
						exp_num.push_back(a[3:0]);
						exp_data.push_back(d);
					end
					"R":
					begin
						rb_addr.push_back(a);
						rb_data.push_back(d);
					end
					default:
						abort_run("cpu_stim.txt holds a record of unknown kind");
				endcase
			end
		end
		$fclose(fd);
	endtask

	// one loader transaction from req through ack and strobe to ready.
	task automatic bus_transfer(input logic do_write, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		repeat ($urandom % 4)
			@(posedge clk);
		@(posedge clk);
		ext_bus.req   <= 1'b1;
		ext_bus.addr  <= addr;
		ext_bus.wdata <= wdata;
		do
			@(negedge clk);
		while (!ext_ack);
		@(posedge clk);
		ext_bus.rd <= !do_write;
		ext_bus.wr <= do_write;
		@(posedge clk);
		ext_bus.rd <= 1'b0;
		ext_bus.wr <= 1'b0;
		do
			@(negedge clk);
		while (!ext_rsp.ready);
		rdata = ext_rsp.rdata;
		@(posedge clk);
		ext_bus.req <= 1'b0;
	endtask

	task automatic read_back_all();
		logic [31:0] rdata;
		for (int i = 0; i < rb_addr.size(); i++)
		begin
			bus_transfer(1'b0, rb_addr[i], 32'd0, rdata);
			compare_word("ext_rsp.rdata", rb_data[i], rdata);
		end
	endtask

	task automatic check_commits();
		while (commits_seen < exp_data.size())
		begin
			@(negedge clk);
			if (commit.valid)
			begin
				compare_word("commit.num", {28'd0, exp_num[commits_seen]},
					{28'd0, commit.num});
				compare_word("commit.data", exp_data[commits_seen], commit.data);
				commits_seen++;
			end
		end
	endtask

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit)
				abort_run($sformatf("timeout: run still busy after %0d cycles",
					cycle_count));
		end
	end

	initial
	begin
		logic [31:0] rdata;
		seed_draw    = $urandom(57195);
		reset        = 1'b1;
		run          = 1'b0;
		ext_bus      = '0;
		commits_seen = 0;
		cycle_limit  = 0;
		load_stimulus();
		cycle_limit = 40 * prog_data.size() + 40 * exp_data.size() + 200;
		repeat (8)
			@(posedge clk);
		reset <= 1'b0;

		// core halted while the program image goes in.
		for (int i = 0; i < prog_addr.size(); i++)
			bus_transfer(1'b1, prog_addr[i], prog_data[i], rdata);
		read_back_all();

		@(posedge clk);
		run <= 1'b1;
		fork
			check_commits();
			read_back_all();
		join
		@(posedge clk);
		run <= 1'b0;

		$display(">>> PASS");
		$finish;
	end

endmodule
